// ==== compile.f ====
+incdir+include
verilog/csr_pkg.sv
verilog/trap_entry_if.sv
verilog/priv_trap_fsm.sv
verilog/trap_csr_bank.sv
verilog/cycle_counter.sv
verilog/csr_wb_port.sv
verilog/csr_unit_top.sv
test/csr_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the CSR unit testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= No errors

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The pass line must appear on a line of its own, otherwise the target fails
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/csr_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
();

    localparam word_t TB_VENDOR_ID = 32'h0000_0A5C;
    localparam word_t TB_HART_ID   = 32'h0000_0007;
    localparam int    ACK_TIMEOUT  = 20;
    // MXL = 1 for RV32 and the I extension bit
    localparam word_t EXP_MISA     = 32'h4000_0100;
    // SIE, SPIE and SPP
    localparam word_t SSTATUS_BITS = 32'h0000_0122;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_TRAP,
        OP_MRET,
        OP_SRET
    } op_t;

    // TRAP rows carry {is_interrupt, code} in addr and the trap PC in data
    typedef struct packed {
        op_t       op;
        csr_addr_t addr;
        word_t     data;
        word_t     exp_val;
        priv_t     exp_priv;
    } step_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    csr_addr_t  wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_ack;
    logic       trap_valid;
    logic [3:0] trap_cause_code;
    logic       trap_is_interrupt;
    word_t      trap_pc;
    word_t      trap_value;
    logic       trap_return;
    priv_t      trap_return_priv;
    priv_t      priv;
    mstatus_t   mstatus;
    word_t      mtvec;
    word_t      stvec;
    word_t      mepc;
    word_t      sepc;

    step_t  steps[$];
    int     errors;
    int     checks;
    integer seed;
    word_t  rd_word;
    word_t  cyc_first;
    word_t  cyc_second;

    always #50 clk = ~clk;

    csr_unit_top #(
        .VENDOR_ID (TB_VENDOR_ID),
        .HART_ID   (TB_HART_ID)
    ) dut_i (
        .clk               (clk),
        .rst               (rst),
        .wb_cyc            (wb_cyc),
        .wb_stb            (wb_stb),
        .wb_we             (wb_we),
        .wb_adr            (wb_adr),
        .wb_dat_w          (wb_dat_w),
        .wb_dat_r          (wb_dat_r),
        .wb_ack            (wb_ack),
        .trap_valid        (trap_valid),
        .trap_cause_code   (trap_cause_code),
        .trap_is_interrupt (trap_is_interrupt),
        .trap_pc           (trap_pc),
        .trap_value        (trap_value),
        .trap_return       (trap_return),
        .trap_return_priv  (trap_return_priv),
        .priv              (priv),
        .mstatus           (mstatus),
        .mtvec             (mtvec),
        .stvec             (stvec),
        .mepc              (mepc),
        .sepc              (sepc)
    );

    // ------------------------------------------------------------------------
    // Checker and bus tasks
    task automatic compare_word(input string name, input word_t got, input word_t exp_val);
        checks++;
        if (got !== exp_val) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $time, name, got, exp_val);
        end
    endtask

    // Ack sampled on the falling edge between update edges
    task automatic wait_ack(input csr_addr_t addr);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wb_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!wb_ack) begin
            errors++;
            $display("Timeout: no wb_ack for CSR %h within %0d cycles", addr, ACK_TIMEOUT);
        end
    endtask

    task automatic end_cycle();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input csr_addr_t addr, input word_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        wait_ack(addr);
        end_cycle();
    endtask

    task automatic wb_read(input csr_addr_t addr, output word_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        wait_ack(addr);
        data = wb_dat_r;
        end_cycle();
    endtask

    // Trap value is the inverted PC so tval and epc differ
    task automatic do_trap(input logic [4:0] cause, input word_t pc,
                           input word_t exp_epc, input priv_t exp_priv);
        @(posedge clk);
        trap_valid        <= 1'b1;
        trap_is_interrupt <= cause[4];
        trap_cause_code   <= cause[3:0];
        trap_pc           <= pc;
        trap_value        <= ~pc;
        @(posedge clk);
        trap_valid <= 1'b0;
        @(negedge clk);
        if (exp_priv == PRIV_S) begin
            compare_word("sepc", sepc, exp_epc);
        end else begin
            compare_word("mepc", mepc, exp_epc);
        end
    endtask

    task automatic do_return(input priv_t from_priv, input word_t exp_status);
        @(posedge clk);
        trap_return      <= 1'b1;
        trap_return_priv <= from_priv;
        @(posedge clk);
        trap_return <= 1'b0;
        @(negedge clk);
        compare_word("mstatus", word_t'(mstatus), exp_status);
    endtask

    function automatic void add_step(op_t op, csr_addr_t addr, word_t data,
                                     word_t exp_val, priv_t exp_priv);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.exp_val  = exp_val;
        s.exp_priv = exp_priv;
        steps.push_back(s);
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus table
    function automatic void build_table();
        word_t mscratch_w;
        word_t mtvec_w;
        word_t sscratch_w;
        word_t stvec_w;
        word_t deleg_w;
        word_t pc_m;
        word_t pc_s;
        mscratch_w = $random(seed);
        mtvec_w    = $random(seed);
        sscratch_w = $random(seed);
        stvec_w    = $random(seed);
        deleg_w    = $random(seed);
        pc_m       = word_t'($random(seed)) & 32'hFFFF_FFFC;
        pc_s       = word_t'($random(seed)) & 32'hFFFF_FFFC;

        // Constant registers
        add_step(OP_READ,  CSR_MISA,      '0, EXP_MISA,     PRIV_M);
        add_step(OP_READ,  CSR_MHARTID,   '0, TB_HART_ID,   PRIV_M);
        add_step(OP_READ,  CSR_MVENDORID, '0, TB_VENDOR_ID, PRIV_M);
        // Plain read and write
        add_step(OP_WRITE, CSR_MSCRATCH, mscratch_w, mscratch_w, PRIV_M);
        add_step(OP_READ,  CSR_MSCRATCH, '0,         mscratch_w, PRIV_M);
        add_step(OP_WRITE, CSR_MTVEC,    mtvec_w,    mtvec_w,    PRIV_M);
        add_step(OP_READ,  CSR_MTVEC,    '0,         mtvec_w,    PRIV_M);
        add_step(OP_WRITE, CSR_SSCRATCH, sscratch_w, sscratch_w, PRIV_M);
        add_step(OP_READ,  CSR_SSCRATCH, '0,         sscratch_w, PRIV_M);
        add_step(OP_WRITE, CSR_STVEC,    stvec_w,    stvec_w,    PRIV_M);
        add_step(OP_READ,  CSR_STVEC,    '0,         stvec_w,    PRIV_M);
        add_step(OP_WRITE, CSR_MEDELEG,  deleg_w,    deleg_w,    PRIV_M);
        add_step(OP_READ,  CSR_MEDELEG,  '0,         deleg_w,    PRIV_M);
        // MPP = M and MIE before an all-ones sstatus write
        add_step(OP_WRITE, CSR_MSTATUS, 32'h0000_1808, '0,            PRIV_M);
        add_step(OP_READ,  CSR_MSTATUS, '0,            32'h0000_1808, PRIV_M);
        add_step(OP_WRITE, CSR_SSTATUS, 32'hFFFF_FFFF, '0,            PRIV_M);
        add_step(OP_READ,  CSR_MSTATUS, '0, 32'h0000_1808 | SSTATUS_BITS, PRIV_M);
        add_step(OP_READ,  CSR_SSTATUS, '0, SSTATUS_BITS,               PRIV_M);
        // Interrupt 3 stays in machine mode
        add_step(OP_WRITE, CSR_MEDELEG, '0, '0, PRIV_M);
        add_step(OP_WRITE, CSR_MSTATUS, '0, '0, PRIV_M);
        add_step(OP_TRAP,  12'h013,     pc_m, pc_m,               PRIV_M);
        add_step(OP_READ,  CSR_MEPC,    '0,   pc_m,               PRIV_M);
        add_step(OP_READ,  CSR_MCAUSE,  '0,   {1'b1, 27'd0, 4'd3}, PRIV_M);
        add_step(OP_READ,  CSR_MTVAL,   '0,   ~pc_m,              PRIV_M);
        add_step(OP_READ,  CSR_MSTATUS, '0,   32'h0000_1800,      PRIV_M);
        add_step(OP_MRET,  '0,          '0,   32'h0000_0000,      PRIV_M);
        // Exception 5 delegated and entered from S after an mret with MPP = S
        add_step(OP_WRITE, CSR_MEDELEG, 32'h1 << 5,    '0, PRIV_M);
        add_step(OP_WRITE, CSR_MSTATUS, 32'h0000_0800, '0, PRIV_M);
        add_step(OP_MRET,  '0,          '0, 32'h0000_0000, PRIV_S);
        add_step(OP_TRAP,  12'h005,     pc_s, pc_s,               PRIV_S);
        add_step(OP_READ,  CSR_SEPC,    '0,   pc_s,               PRIV_S);
        add_step(OP_READ,  CSR_SCAUSE,  '0,   {1'b0, 27'd0, 4'd5}, PRIV_S);
        add_step(OP_READ,  CSR_STVAL,   '0,   ~pc_s,              PRIV_S);
        add_step(OP_READ,  CSR_MEPC,    '0,   pc_m,               PRIV_S);
        add_step(OP_READ,  CSR_MSTATUS, '0,   32'h0000_0100,      PRIV_S);
        add_step(OP_SRET,  '0,          '0,   32'h0000_0000,      PRIV_S);
        // Upper counter half is still zero
        add_step(OP_READ,  CSR_CYCLEH,  '0,   '0,                 PRIV_S);
    endfunction

    // ------------------------------------------------------------------------
    initial begin
        errors = 0;
        checks = 0;
        seed   = 32'h42df;
        rst               <= 1'b1;
        wb_cyc            <= 1'b0;
        wb_stb            <= 1'b0;
        wb_we             <= 1'b0;
        wb_adr            <= '0;
        wb_dat_w          <= '0;
        trap_valid        <= 1'b0;
        trap_cause_code   <= '0;
        trap_is_interrupt <= 1'b0;
        trap_pc           <= '0;
        trap_value        <= '0;
        trap_return       <= 1'b0;
        trap_return_priv  <= PRIV_M;
        build_table();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_word("priv", word_t'(priv), word_t'(PRIV_M));
        compare_word("mtvec", mtvec, '0);
        compare_word("mepc", mepc, '0);

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WRITE: wb_write(steps[i].addr, steps[i].data);
                OP_READ: begin
                    wb_read(steps[i].addr, rd_word);
                    compare_word($sformatf("csr %h", steps[i].addr), rd_word, steps[i].exp_val);
                end
                OP_TRAP: do_trap(steps[i].addr[4:0], steps[i].data,
                                 steps[i].exp_val, steps[i].exp_priv);
                OP_MRET: do_return(PRIV_M, steps[i].exp_val);
                OP_SRET: do_return(PRIV_S, steps[i].exp_val);
                default: ;
            endcase
            @(negedge clk);
            if (steps[i].op == OP_WRITE && steps[i].addr == CSR_MTVEC) begin
                compare_word("mtvec", mtvec, steps[i].exp_val);
            end
            if (steps[i].op == OP_WRITE && steps[i].addr == CSR_STVEC) begin
                compare_word("stvec", stvec, steps[i].exp_val);
            end
            compare_word("priv", word_t'(priv), word_t'(steps[i].exp_priv));
        end

        // Counter moves between two reads a few transfers apart
        wb_read(CSR_CYCLE, cyc_first);
        wb_read(CSR_MSCRATCH, rd_word);
        wb_read(CSR_MSCRATCH, rd_word);
        wb_read(CSR_CYCLE, cyc_second);
        compare_word("cycle advanced", word_t'(cyc_second > cyc_first), 32'd1);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_unit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit_top
    import csr_pkg::*;
#(
    parameter word_t VENDOR_ID   = '0,
    parameter word_t HART_ID     = '0,
    parameter int    CYCLE_WIDTH = 64
) (
    input  logic      clk,
    input  logic      rst,
    // Wishbone slave
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  csr_addr_t wb_adr,
    input  word_t     wb_dat_w,
    output word_t     wb_dat_r,
    output logic      wb_ack,
    // Trap events from the core
    input  logic       trap_valid,
    input  logic [3:0] trap_cause_code,
    input  logic       trap_is_interrupt,
    input  word_t      trap_pc,
    input  word_t      trap_value,
    input  logic       trap_return,
    input  priv_t      trap_return_priv,
    // State seen by the core
    output priv_t      priv,
    output mstatus_t   mstatus,
    output word_t      mtvec,
    output word_t      stvec,
    output word_t      mepc,
    output word_t      sepc
);

    trap_cause_t trap_cause;
    logic        wr_en;
    csr_addr_t   wr_addr;
    word_t       wr_data;
    word_t       fsm_rd;
    word_t       m_rd;
    word_t       s_rd;
    word_t       cnt_rd;

    trap_entry_if entry_if ();

    assign trap_cause.is_interrupt = trap_is_interrupt;
    assign trap_cause.code         = trap_cause_code;

    // ------------------------------------------------------------------------
    priv_trap_fsm fsm_i (
        .clk              (clk),
        .rst              (rst),
        .trap_valid       (trap_valid),
        .trap_cause       (trap_cause),
        .trap_pc          (trap_pc),
        .trap_value       (trap_value),
        .trap_return      (trap_return),
        .trap_return_priv (trap_return_priv),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .rd_addr          (wb_adr),
        .rd_data          (fsm_rd),
        .priv             (priv),
        .mstatus          (mstatus),
        .entry            (entry_if.fsm)
    );

    trap_csr_bank #(.BANK_PRIV(PRIV_M)) m_bank_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (wb_adr),
        .rd_data (m_rd),
        .tvec    (mtvec),
        .epc     (mepc),
        .entry   (entry_if.bank)
    );

    trap_csr_bank #(.BANK_PRIV(PRIV_S)) s_bank_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (wb_adr),
        .rd_data (s_rd),
        .tvec    (stvec),
        .epc     (sepc),
        .entry   (entry_if.bank)
    );

    cycle_counter #(.CYCLE_WIDTH(CYCLE_WIDTH)) cycle_i (
        .clk     (clk),
        .rst     (rst),
        .rd_addr (wb_adr),
        .rd_data (cnt_rd)
    );

    csr_wb_port #(
        .VENDOR_ID (VENDOR_ID),
        .HART_ID   (HART_ID)
    ) wb_port_i (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .trap_valid  (trap_valid),
        .trap_return (trap_return),
        .fsm_rd      (fsm_rd),
        .m_rd        (m_rd),
        .s_rd        (s_rd),
        .cnt_rd      (cnt_rd),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

endmodule

`default_nettype wire

// ==== verilog/csr_wb_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_wb_port
    import csr_pkg::*;
#(
    parameter word_t VENDOR_ID = '0,
    parameter word_t HART_ID   = '0
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  csr_addr_t wb_adr,
    input  word_t     wb_dat_w,
    output word_t     wb_dat_r,
    output logic      wb_ack,
    input  logic      trap_valid,
    input  logic      trap_return,
    input  word_t     fsm_rd,
    input  word_t     m_rd,
    input  word_t     s_rd,
    input  word_t     cnt_rd,
    output logic      wr_en,
    output csr_addr_t wr_addr,
    output word_t     wr_data
);

    logic  req;
    logic  accept;
    word_t const_rd;
    word_t rd_merge;

    // ------------------------------------------------------------------------
    // Handshake with trap events stalling the acknowledge
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign accept = req && !(trap_valid || trap_return);

    // Write lands on the edge that raises ack
    assign wr_en   = accept && wb_we;
    assign wr_addr = wb_adr;
    assign wr_data = wb_dat_w;

    always_comb begin
        case (wb_adr)
            CSR_MISA:      const_rd = MISA_VALUE;
            CSR_MVENDORID: const_rd = VENDOR_ID;
            CSR_MHARTID:   const_rd = HART_ID;
            default:       const_rd = '0;
        endcase
    end

    // Unselected sources return zero
    assign rd_merge = const_rd | fsm_rd | m_rd | s_rd | cnt_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_dat_r <= '0;
        end else if (accept && !wb_we) begin
            wb_dat_r <= rd_merge;
        end
    end

    // ------------------------------------------------------------------------
    // Bus protocol
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack without an active cycle");

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

endmodule

`default_nettype wire

// ==== verilog/cycle_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module cycle_counter
    import csr_pkg::*;
#(
    parameter int CYCLE_WIDTH = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  csr_addr_t rd_addr,
    output word_t     rd_data
);

    localparam int EXT_W = 2 * XLEN;

    logic [CYCLE_WIDTH-1:0] count;
    logic [EXT_W-1:0]       count_ext;

    // Narrow counters read with zeros in the upper half
    assign count_ext = EXT_W'(count);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_comb begin
        case (rd_addr)
            CSR_CYCLE:  rd_data = count_ext[XLEN-1:0];
            CSR_CYCLEH: rd_data = count_ext[EXT_W-1:XLEN];
            default:    rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/trap_csr_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module trap_csr_bank
    import csr_pkg::*;
#(
    parameter priv_t BANK_PRIV = PRIV_M
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  csr_addr_t  wr_addr,
    input  word_t      wr_data,
    input  csr_addr_t  rd_addr,
    output word_t      rd_data,
    output word_t      tvec,
    output word_t      epc,
    trap_entry_if.bank entry
);

    localparam bit        IS_M          = (BANK_PRIV == PRIV_M);
    localparam csr_addr_t ADDR_TVEC     = IS_M ? CSR_MTVEC    : CSR_STVEC;
    localparam csr_addr_t ADDR_SCRATCH  = IS_M ? CSR_MSCRATCH : CSR_SSCRATCH;
    localparam csr_addr_t ADDR_EPC      = IS_M ? CSR_MEPC     : CSR_SEPC;
    localparam csr_addr_t ADDR_CAUSE    = IS_M ? CSR_MCAUSE   : CSR_SCAUSE;
    localparam csr_addr_t ADDR_TVAL     = IS_M ? CSR_MTVAL    : CSR_STVAL;

    trap_cause_t cause;
    word_t       tval;
    word_t       scratch;
    logic        capture;

    assign capture = entry.take && (entry.target == BANK_PRIV);

    always_ff @(posedge clk) begin
        if (rst) begin
            epc     <= '0;
            cause   <= '0;
            tval    <= '0;
            tvec    <= '0;
            scratch <= '0;
        end else if (capture) begin
            epc   <= entry.pc;
            cause <= entry.cause;
            tval  <= entry.tval;
        end else if (wr_en) begin
            case (wr_addr)
                ADDR_EPC:     epc     <= wr_data;
                ADDR_CAUSE:   cause   <= {wr_data[31], wr_data[3:0]};
                ADDR_TVAL:    tval    <= wr_data;
                ADDR_TVEC:    tvec    <= wr_data;
                ADDR_SCRATCH: scratch <= wr_data;
                default:      ;
            endcase
        end
    end

    always_comb begin
        case (rd_addr)
            ADDR_EPC:     rd_data = epc;
            ADDR_CAUSE:   rd_data = cause_word(cause);
            ADDR_TVAL:    rd_data = tval;
            ADDR_TVEC:    rd_data = tvec;
            ADDR_SCRATCH: rd_data = scratch;
            default:      rd_data = '0;
        endcase
    end

    a_bank_priv: assert property (@(posedge clk)
        BANK_PRIV == PRIV_M || BANK_PRIV == PRIV_S)
        else $error("trap bank built for an unsupported privilege");

endmodule

`default_nettype wire

// ==== verilog/priv_trap_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module priv_trap_fsm
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        trap_valid,
    input  trap_cause_t trap_cause,
    input  word_t       trap_pc,
    input  word_t       trap_value,
    input  logic        trap_return,
    input  priv_t       trap_return_priv,
    input  logic        wr_en,
    input  csr_addr_t   wr_addr,
    input  word_t       wr_data,
    input  csr_addr_t   rd_addr,
    output word_t       rd_data,
    output priv_t       priv,
    output mstatus_t    mstatus,
    trap_entry_if.fsm   entry
);

    word_t    medeleg;
    priv_t    trap_target;
    priv_t    next_priv;
    mstatus_t next_status;

    // Delegation by exception code
    assign trap_target = medeleg[trap_cause.code] ? PRIV_S : PRIV_M;

    assign entry.take   = trap_valid;
    assign entry.target = trap_target;
    assign entry.cause  = trap_cause;
    assign entry.pc     = trap_pc;
    assign entry.tval   = trap_value;

    // ------------------------------------------------------------------------
    // Next privilege and status
    always_comb begin
        next_priv   = priv;
        next_status = mstatus;
        if (trap_valid) begin
            next_priv = trap_target;
            if (trap_target == PRIV_M) begin
                next_status.mpp = priv;
            end else begin
                // U and S differ only in bit 0
                next_status.spp = priv[0];
            end
        end else if (trap_return) begin
            if (trap_return_priv == PRIV_M) begin
                next_priv       = priv_t'(mstatus.mpp);
                next_status.mpp = PRIV_U;
                next_status.mie = mstatus.mpie;
            end else begin
                next_priv       = mstatus.spp ? PRIV_S : PRIV_U;
                next_status.spp = 1'b0;
                next_status.sie = mstatus.spie;
            end
        end else if (wr_en && wr_addr == CSR_MSTATUS) begin
            next_status = write_mstatus(mstatus, wr_data);
        end else if (wr_en && wr_addr == CSR_SSTATUS) begin
            next_status = write_sstatus(mstatus, wr_data);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv    <= PRIV_M;
            mstatus <= '0;
            medeleg <= '0;
        end else begin
            priv    <= next_priv;
            mstatus <= next_status;
            if (wr_en && wr_addr == CSR_MEDELEG) begin
                medeleg <= wr_data;
            end
        end
    end

    always_comb begin
        case (rd_addr)
            CSR_MSTATUS: rd_data = mstatus;
            CSR_SSTATUS: rd_data = mstatus & SSTATUS_MASK;
            CSR_MEDELEG: rd_data = medeleg;
            default:     rd_data = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Core side guarantees
    a_trap_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(trap_valid && trap_return))
        else $error("trap_valid and trap_return high together");

    a_priv_legal: assert property (@(posedge clk) disable iff (rst)
        priv != 2'b10)
        else $error("priv holds the reserved encoding");

endmodule

`default_nettype wire

// ==== verilog/trap_entry_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// One trap-entry event per cycle for both register banks
interface trap_entry_if
    import csr_pkg::*;
();

    logic        take;
    priv_t       target;
    trap_cause_t cause;
    word_t       pc;
    word_t       tval;

    modport fsm (output take, target, cause, pc, tval);

    modport bank (input take, target, cause, pc, tval);

endinterface

`default_nettype wire

// ==== verilog/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [11:0]     csr_addr_t;

    // Encoding 2 is reserved
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef struct packed {
        logic       is_interrupt;
        logic [3:0] code;
    } trap_cause_t;

    // ------------------------------------------------------------------------
    // Status register layout with unimplemented bits reading as zero
    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;
        logic [1:0]  rsvd_10_9;
        logic        spp;
        logic        mpie;
        logic        rsvd_6;
        logic        spie;
        logic        rsvd_4;
        logic        mie;
        logic        rsvd_2;
        logic        sie;
        logic        rsvd_0;
    } mstatus_t;

    // SIE, SPIE and SPP
    localparam word_t SSTATUS_MASK = 32'h0000_0122;
    // Every implemented mstatus field
    localparam word_t MSTATUS_MASK = 32'h0000_19AA;
    // RV32I
    localparam word_t MISA_VALUE   = 32'h4000_0100;

    `include "csr_addr.svh"

    function automatic word_t cause_word(trap_cause_t cause);
        return {cause.is_interrupt, 27'b0, cause.code};
    endfunction

    // Reserved MPP encoding keeps the old value
    function automatic mstatus_t write_mstatus(mstatus_t cur, word_t wdata);
        mstatus_t nxt;
        nxt = mstatus_t'(wdata & MSTATUS_MASK);
        if (nxt.mpp == 2'b10) begin
            nxt.mpp = cur.mpp;
        end
        return nxt;
    endfunction

    function automatic mstatus_t write_sstatus(mstatus_t cur, word_t wdata);
        return mstatus_t'((cur & ~SSTATUS_MASK) | (wdata & SSTATUS_MASK));
    endfunction

endpackage

`default_nettype wire

// ==== include/csr_addr.svh ====
`ifndef CSR_ADDR_SVH
`define CSR_ADDR_SVH

// Supervisor trap setup and handling
localparam csr_addr_t CSR_SSTATUS   = 12'h100;
localparam csr_addr_t CSR_STVEC     = 12'h105;
localparam csr_addr_t CSR_SSCRATCH  = 12'h140;
localparam csr_addr_t CSR_SEPC      = 12'h141;
localparam csr_addr_t CSR_SCAUSE    = 12'h142;
localparam csr_addr_t CSR_STVAL     = 12'h143;

// Machine trap setup and handling
localparam csr_addr_t CSR_MSTATUS   = 12'h300;
localparam csr_addr_t CSR_MISA      = 12'h301;
localparam csr_addr_t CSR_MEDELEG   = 12'h302;
localparam csr_addr_t CSR_MTVEC     = 12'h305;
localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
localparam csr_addr_t CSR_MEPC      = 12'h341;
localparam csr_addr_t CSR_MCAUSE    = 12'h342;
localparam csr_addr_t CSR_MTVAL     = 12'h343;

// Counters and machine information
localparam csr_addr_t CSR_CYCLE     = 12'hC00;
localparam csr_addr_t CSR_CYCLEH    = 12'hC80;
localparam csr_addr_t CSR_MVENDORID = 12'hF11;
localparam csr_addr_t CSR_MHARTID   = 12'hF14;

`endif
